// File: riscv_csrfile.f
+incdir+tb
logic/riscv_csr_pkg.sv
logic/csr_op_decode.sv
logic/csr_trap_ctrl.sv
logic/csr_regs.sv
logic/csr_read_mux.sv
logic/riscv_csrfile.sv
tb/tb_riscv_csrfile.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_riscv_csrfile
FILELIST  ?= riscv_csrfile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: tb/tb_csr_tasks.svh
`ifndef TB_CSR_TASKS_SVH
`define TB_CSR_TASKS_SVH

// one cycle on the csr port with inputs changed on the falling edge
task automatic csr_access(input logic [2:0] acc_op, input logic [11:0] acc_addr,
                          input logic [63:0] acc_data);
    @(negedge clk);
    op       = acc_op;
    address  = acc_addr;
    wdata    = acc_data;
    exc      = exc_next;
    ext_int  = ext_next;
    tmr_int  = tmr_next;
    pc       = pc_next;
    alu_addr = alu_next;
    // exception flags last one cycle only
    exc_next = 7'd0;
    // sample well before the rising edge
    #1;
    rdata_s     = rdata;
    trap_s      = goto_trap;
    ret_s       = ret_trap;
    flush_s     = flush;
    ret_addr_s  = ret_addr;
    trap_addr_s = trap_addr;
endtask

task automatic rand_word(output logic [63:0] v);
    v = {$random(seed), $random(seed)};
endtask

task automatic check_word(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
        $display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
        errors++;
        test_errors++;
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
        $display("Fail at %0t: %s = %b, expected %b", $time, name, got, exp);
        errors++;
        test_errors++;
    end
endtask

// read op then compare
task automatic expect_csr(input string name, input logic [11:0] addr, input logic [63:0] exp);
    csr_access(CSR_READ, addr, 64'd0);
    check_word(name, rdata_s, exp);
endtask

task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
        $display("test %s: ok", name);
    end else begin
        tests_failed++;
        $display("test %s: %0d errors", name, test_errors);
    end
    test_errors = 0;
endtask

// lowest index wins as index order follows exception priority
function automatic int first_exception(input logic [6:0] vec);
    int idx;
    idx = 7;
    for (int b = 6; b >= 0; b--) begin
        if (vec[b]) begin
            idx = b;
        end
    end
    return idx;
endfunction

task automatic reset_reads_test();
    expect_csr("mstatus", CSR_MSTATUS, 64'd0);
    check_bit("gotoTrap", trap_s, 1'b0);
    check_bit("returnfromTrap", ret_s, 1'b0);
    check_bit("sideeffect_flush", flush_s, 1'b0);
    expect_csr("mtvec", CSR_MTVEC, 64'd0);
    expect_csr("mepc", CSR_MEPC, 64'd0);
    expect_csr("mcause", CSR_MCAUSE, 64'd0);
    check_word("return_address", ret_addr_s, 64'd0);
    check_word("trap_address", trap_addr_s, 64'd0);
    expect_csr("misa", CSR_MISA, MISA_EXP);
    expect_csr("mvendorid", CSR_MVENDORID, 64'd0);
    // idle gives no data even on a live address
    csr_access(CSR_IDLE, CSR_MISA, 64'hFFFF_FFFF_FFFF_FFFF);
    check_word("rdata on idle", rdata_s, 64'd0);
    finish_test("reset_reads");
endtask

task automatic write_set_clear_test();
    logic [11:0] addrs [3];
    logic [63:0] masks [3];
    string       names [3];
    logic [63:0] model;
    logic [63:0] val;
    int          i;
    addrs = '{CSR_MSCRATCH, CSR_MTVAL, CSR_MIE};
    masks = '{64'hFFFF_FFFF_FFFF_FFFF, 64'hFFFF_FFFF_FFFF_FFFF, MEIE | MTIE};
    names = '{"mscratch", "mtval", "mie"};
    for (i = 0; i < 3; i++) begin
        // all three start from reset zero
        model = 64'd0;
        rand_word(val);
        csr_access(CSR_WRITE, addrs[i], val);
        check_word({names[i], " old value"}, rdata_s, model);
        check_bit("sideeffect_flush", flush_s, 1'b0);
        model = val & masks[i];
        expect_csr({names[i], " after write"}, addrs[i], model);
        rand_word(val);
        csr_access(CSR_SET, addrs[i], val);
        check_word({names[i], " old value on set"}, rdata_s, model);
        model = (model | val) & masks[i];
        expect_csr({names[i], " after set"}, addrs[i], model);
        rand_word(val);
        csr_access(CSR_CLEAR, addrs[i], val);
        check_word({names[i], " old value on clear"}, rdata_s, model);
        model = model & ~val;
        expect_csr({names[i], " after clear"}, addrs[i], model);
    end
    csr_access(CSR_WRITE, CSR_MIE, 64'd0);
    // alignment bits drop on write
    rand_word(val);
    csr_access(CSR_WRITE, CSR_MEPC, val);
    expect_csr("mepc", CSR_MEPC, val & ~64'd1);
    rand_word(val);
    csr_access(CSR_WRITE, CSR_MTVEC, val);
    expect_csr("mtvec", CSR_MTVEC, val & ~64'd3);
    rand_word(val);
    csr_access(CSR_WRITE, 12'h7C0, val);
    expect_csr("unknown csr", 12'h7C0, 64'd0);
    // flush only for mstatus modify ops
    csr_access(CSR_WRITE, CSR_MSTATUS, 64'd0);
    check_bit("sideeffect_flush on write", flush_s, 1'b1);
    csr_access(CSR_SET, CSR_MSTATUS, 64'd0);
    check_bit("sideeffect_flush on set", flush_s, 1'b1);
    csr_access(CSR_CLEAR, CSR_MSTATUS, 64'd0);
    check_bit("sideeffect_flush on clear", flush_s, 1'b1);
    csr_access(CSR_READ, CSR_MSTATUS, 64'd0);
    check_bit("sideeffect_flush on read", flush_s, 1'b0);
    finish_test("write_set_clear");
endtask

task automatic exceptions_test();
    logic [63:0] codes [7];
    logic [63:0] pc_val;
    logic [63:0] alu_val;
    logic [63:0] exp_tval;
    logic [6:0]  vec;
    logic        mie_before;
    int          i;
    int          k;
    codes = '{64'd0, 64'd2, 64'd8, 64'd9, 64'd11, 64'd4, 64'd6};
    for (i = 0; i < 7; i++) begin
        // alternate the old MIE so MPIE sees both values
        mie_before = (i % 2 == 0);
        csr_access(CSR_WRITE, CSR_MSTATUS, mie_before ? MS_MIE : 64'd0);
        rand_word(pc_val);
        pc_val[1:0] = 2'b00;
        rand_word(alu_val);
        pc_next  = pc_val;
        alu_next = alu_val;
        exc_next = 7'd1 << i;
        csr_access(CSR_IDLE, 12'd0, 64'd0);
        check_bit("gotoTrap", trap_s, 1'b1);
        check_bit("returnfromTrap", ret_s, 1'b0);
        expect_csr("mepc", CSR_MEPC, pc_val);
        check_word("return_address", ret_addr_s, pc_val);
        expect_csr("mcause", CSR_MCAUSE, codes[i]);
        // only the misaligned causes report the address
        exp_tval = (i == 0 || i == 5 || i == 6) ? alu_val : 64'd0;
        expect_csr("mtval", CSR_MTVAL, exp_tval);
        expect_csr("mstatus", CSR_MSTATUS, MS_MPP_M | (mie_before ? MS_MPIE : 64'd0));
    end
    // several causes at once
    for (k = 0; k < 4; k++) begin
        rand_word(alu_val);
        vec = alu_val[6:0];
        if (vec == 7'd0) begin
            vec = 7'b100_0000;
        end
        exc_next = vec;
        csr_access(CSR_IDLE, 12'd0, 64'd0);
        check_bit("gotoTrap", trap_s, 1'b1);
        expect_csr("mcause with several causes", CSR_MCAUSE, codes[first_exception(vec)]);
    end
    finish_test("exceptions");
endtask

task automatic interrupts_test();
    logic [63:0] tv;
    csr_access(CSR_WRITE, CSR_MSTATUS, 64'd0);
    rand_word(tv);
    tv[1:0] = 2'b00;
    csr_access(CSR_WRITE, CSR_MTVEC, tv);
    // line up but globally masked
    ext_next = 1'b1;
    csr_access(CSR_READ, CSR_MIP, 64'd0);
    check_word("mip", rdata_s, MEIE);
    check_bit("gotoTrap", trap_s, 1'b0);
    csr_access(CSR_WRITE, CSR_MIE, MEIE);
    check_bit("gotoTrap", trap_s, 1'b0);
    csr_access(CSR_WRITE, CSR_MSTATUS, MS_MIE);
    check_bit("gotoTrap", trap_s, 1'b0);
    // enable now visible
    csr_access(CSR_IDLE, 12'd0, 64'd0);
    check_bit("gotoTrap", trap_s, 1'b1);
    check_word("trap_address", trap_addr_s, tv);
    expect_csr("mcause", CSR_MCAUSE, INT_FLAG | 64'd11);
    expect_csr("mstatus", CSR_MSTATUS, MS_MPIE | MS_MPP_M);
    // timer alone
    ext_next = 1'b0;
    tmr_next = 1'b1;
    csr_access(CSR_WRITE, CSR_MIE, MEIE | MTIE);
    csr_access(CSR_WRITE, CSR_MSTATUS, MS_MIE);
    csr_access(CSR_IDLE, 12'd0, 64'd0);
    check_bit("gotoTrap", trap_s, 1'b1);
    expect_csr("mcause", CSR_MCAUSE, INT_FLAG | 64'd7);
    // both lines with external ranked first
    ext_next = 1'b1;
    csr_access(CSR_WRITE, CSR_MSTATUS, MS_MIE);
    csr_access(CSR_IDLE, 12'd0, 64'd0);
    check_bit("gotoTrap", trap_s, 1'b1);
    expect_csr("mcause", CSR_MCAUSE, INT_FLAG | 64'd11);
    ext_next = 1'b0;
    tmr_next = 1'b0;
    csr_access(CSR_WRITE, CSR_MIE, 64'd0);
    finish_test("interrupts");
endtask

task automatic mret_test();
    logic [63:0] keep;
    csr_access(CSR_WRITE, CSR_MSTATUS, MS_MIE);
    pc_next  = 64'h0000_0000_8000_0100;
    exc_next = 7'b001_0000;
    csr_access(CSR_IDLE, 12'd0, 64'd0);
    check_bit("gotoTrap", trap_s, 1'b1);
    // misa address so a stray read would show up
    csr_access(MRET, CSR_MISA, 64'd0);
    check_bit("returnfromTrap", ret_s, 1'b1);
    check_bit("gotoTrap", trap_s, 1'b0);
    check_word("rdata on mret", rdata_s, 64'd0);
    expect_csr("mstatus", CSR_MSTATUS, MS_MIE | MS_MPIE | MS_MPP_M);
    // MPIE clear so MIE comes back clear
    csr_access(CSR_WRITE, CSR_MSTATUS, 64'd0);
    csr_access(MRET, 12'd0, 64'd0);
    check_bit("returnfromTrap", ret_s, 1'b1);
    expect_csr("mstatus", CSR_MSTATUS, MS_MPIE | MS_MPP_M);
    // exception beats mret
    exc_next = 7'b000_0010;
    csr_access(MRET, 12'd0, 64'd0);
    check_bit("gotoTrap", trap_s, 1'b1);
    check_bit("returnfromTrap", ret_s, 1'b0);
    expect_csr("mcause", CSR_MCAUSE, 64'd2);
    // write in a trap cycle is dropped
    rand_word(keep);
    csr_access(CSR_WRITE, CSR_MSCRATCH, keep);
    exc_next = 7'b000_0010;
    csr_access(CSR_WRITE, CSR_MSCRATCH, ~keep);
    check_bit("gotoTrap", trap_s, 1'b1);
    expect_csr("mscratch", CSR_MSCRATCH, keep);
    exc_next = 7'b000_0010;
    csr_access(CSR_WRITE, CSR_MSTATUS, MS_MIE);
    check_bit("gotoTrap", trap_s, 1'b1);
    check_bit("sideeffect_flush", flush_s, 1'b0);
    expect_csr("mstatus", CSR_MSTATUS, MS_MPP_M);
    finish_test("mret");
endtask

`endif

// File: tb/tb_riscv_csrfile.sv
`timescale 1ns/1ps

module tb_riscv_csrfile import riscv_csr_pkg::*; ();

    // all five tests together take well under 200 cycles
    localparam int TIMEOUT_CYCLES = 2000;

    // expected values taken from the register layout
    localparam logic [63:0] MISA_EXP = 64'h8000_0000_0014_1105;
    localparam logic [63:0] MS_MIE   = 64'h0000_0000_0000_0008;
    localparam logic [63:0] MS_MPIE  = 64'h0000_0000_0000_0080;
    localparam logic [63:0] MS_MPP_M = 64'h0000_0000_0000_1800;
    localparam logic [63:0] MEIE     = 64'h0000_0000_0000_0800;
    localparam logic [63:0] MTIE     = 64'h0000_0000_0000_0080;
    localparam logic [63:0] INT_FLAG = 64'h8000_0000_0000_0000;

    logic        clk;
    logic        rst_n;
    logic [11:0] address;
    logic [2:0]  op;
    logic [63:0] wdata;
    logic        ext_int;
    logic        tmr_int;
    // 0 inst misaligned, 1 illegal, 2..4 ecall u/s/m, 5 load, 6 store
    logic [6:0]  exc;
    logic [63:0] pc;
    logic [63:0] alu_addr;
    logic [63:0] rdata;
    logic        flush;
    logic [63:0] ret_addr;
    logic [63:0] trap_addr;
    logic        goto_trap;
    logic        ret_trap;

    // values applied at the next falling edge
    logic [6:0]  exc_next;
    logic        ext_next;
    logic        tmr_next;
    logic [63:0] pc_next;
    logic [63:0] alu_next;

    // outputs captured mid cycle
    logic [63:0] rdata_s;
    logic        trap_s;
    logic        ret_s;
    logic        flush_s;
    logic [63:0] ret_addr_s;
    logic [63:0] trap_addr_s;

    int     errors = 0;
    int     checks = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     test_errors = 0;
    int     cycles = 0;
    integer seed;

    riscv_csrfile #(.MXLEN(64)) dut0 (
        .i_riscv_csr_clk                   (clk),
        .i_riscv_csr_rst                   (rst_n),
        .i_riscv_csr_address               (address),
        .i_riscv_csr_op                    (op),
        .i_riscv_csr_wdata                 (wdata),
        .o_riscv_csr_rdata                 (rdata),
        .o_riscv_csr_sideeffect_flush      (flush),
        .i_riscv_csr_external_int          (ext_int),
        .i_riscv_csr_timer_int             (tmr_int),
        .i_riscv_csr_illegal_inst          (exc[1]),
        .i_riscv_csr_ecall_u               (exc[2]),
        .i_riscv_csr_ecall_s               (exc[3]),
        .i_riscv_csr_ecall_m               (exc[4]),
        .i_riscv_csr_inst_addr_misaligned  (exc[0]),
        .i_riscv_csr_load_addr_misaligned  (exc[5]),
        .i_riscv_csr_store_addr_misaligned (exc[6]),
        .o_riscv_csr_return_address        (ret_addr),
        .o_riscv_csr_trap_address          (trap_addr),
        .o_riscv_csr_gotoTrap              (goto_trap),
        .o_riscv_csr_returnfromTrap        (ret_trap),
        .i_riscv_csr_pc                    (pc),
        .i_riscv_csr_addressALU            (alu_addr)
    );

    `include "tb_csr_tasks.svh"

    // 8 ns period
    always #4 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        address  = 12'd0;
        op       = 3'd0;
        wdata    = 64'd0;
        ext_int  = 1'b0;
        tmr_int  = 1'b0;
        exc      = 7'd0;
        pc       = 64'd0;
        alu_addr = 64'd0;
        exc_next = 7'd0;
        ext_next = 1'b0;
        tmr_next = 1'b0;
        pc_next  = 64'd0;
        alu_next = 64'd0;
        seed     = 82618;

        // hold reset low for five cycles
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        reset_reads_test();
        write_set_clear_test();
        exceptions_test();
        interrupts_test();
        mret_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: logic/riscv_csrfile.sv
`timescale 1ns/1ps

module riscv_csrfile import riscv_csr_pkg::*; #(
    parameter int MXLEN = 64
) (
    input  logic             i_riscv_csr_clk,
    input  logic             i_riscv_csr_rst,
    input  logic [11:0]      i_riscv_csr_address,
    input  logic [2:0]       i_riscv_csr_op,
    input  logic [MXLEN-1:0] i_riscv_csr_wdata,
    output logic [MXLEN-1:0] o_riscv_csr_rdata,
    output logic             o_riscv_csr_sideeffect_flush,
    // interrupt lines
    input  logic             i_riscv_csr_external_int,
    input  logic             i_riscv_csr_timer_int,
    // exception flags
    input  logic             i_riscv_csr_illegal_inst,
    input  logic             i_riscv_csr_ecall_u,
    input  logic             i_riscv_csr_ecall_s,
    input  logic             i_riscv_csr_ecall_m,
    input  logic             i_riscv_csr_inst_addr_misaligned,
    input  logic             i_riscv_csr_load_addr_misaligned,
    input  logic             i_riscv_csr_store_addr_misaligned,
    // mepc and mtvec straight out to the pc mux
    output logic [MXLEN-1:0] o_riscv_csr_return_address,
    output logic [MXLEN-1:0] o_riscv_csr_trap_address,
    output logic             o_riscv_csr_gotoTrap,
    output logic             o_riscv_csr_returnfromTrap,
    input  logic [MXLEN-1:0] i_riscv_csr_pc,
    input  logic [MXLEN-1:0] i_riscv_csr_addressALU
);

    csr_req_t         req;
    trap_events_t     events;
    trap_info_t       trap;
    mstatus_t         mstatus;
    logic             csr_we;
    logic             csr_read;
    logic             mret_req;
    logic [MXLEN-1:0] csr_wdata;
    logic             meie;
    logic             mtie;
    logic [MXLEN-1:0] mscratch;
    logic [MXLEN-1:0] mtval;
    logic             mcause_int;
    logic [3:0]       mcause_code;

    // bundle the raw ports
    assign req.op      = csr_op_e'(i_riscv_csr_op);
    assign req.address = i_riscv_csr_address;
    assign req.wdata   = i_riscv_csr_wdata;

    assign events.inst_misaligned  = i_riscv_csr_inst_addr_misaligned;
    assign events.illegal          = i_riscv_csr_illegal_inst;
    assign events.ecall_u          = i_riscv_csr_ecall_u;
    assign events.ecall_s          = i_riscv_csr_ecall_s;
    assign events.ecall_m          = i_riscv_csr_ecall_m;
    assign events.load_misaligned  = i_riscv_csr_load_addr_misaligned;
    assign events.store_misaligned = i_riscv_csr_store_addr_misaligned;

    csr_op_decode #(.MXLEN(MXLEN)) u_op_decode (
        .i_req   (req),
        .i_rdata (o_riscv_csr_rdata),
        .o_we    (csr_we),
        .o_read  (csr_read),
        .o_mret  (mret_req),
        .o_wdata (csr_wdata)
    );

    csr_trap_ctrl #(.MXLEN(MXLEN)) u_trap_ctrl (
        .i_events           (events),
        .i_external_int     (i_riscv_csr_external_int),
        .i_timer_int        (i_riscv_csr_timer_int),
        .i_mie_global       (mstatus.mie),
        .i_meie             (meie),
        .i_mtie             (mtie),
        .i_mret             (mret_req),
        .i_addr_alu         (i_riscv_csr_addressALU),
        .o_goto_trap        (o_riscv_csr_gotoTrap),
        .o_return_from_trap (o_riscv_csr_returnfromTrap),
        .o_trap             (trap)
    );

    csr_regs #(.MXLEN(MXLEN)) u_regs (
        .i_riscv_csr_clk    (i_riscv_csr_clk),
        .i_riscv_csr_rst    (i_riscv_csr_rst),
        .i_address          (req.address),
        .i_we               (csr_we),
        .i_wdata            (csr_wdata),
        .i_goto_trap        (o_riscv_csr_gotoTrap),
        .i_return_from_trap (o_riscv_csr_returnfromTrap),
        .i_trap             (trap),
        .i_pc               (i_riscv_csr_pc),
        .o_mstatus          (mstatus),
        .o_meie             (meie),
        .o_mtie             (mtie),
        .o_mtvec            (o_riscv_csr_trap_address),
        .o_mscratch         (mscratch),
        .o_mepc             (o_riscv_csr_return_address),
        .o_mtval            (mtval),
        .o_mcause_int       (mcause_int),
        .o_mcause_code      (mcause_code),
        .o_flush            (o_riscv_csr_sideeffect_flush)
    );

    csr_read_mux #(.MXLEN(MXLEN)) u_read_mux (
        .i_address      (req.address),
        .i_read         (csr_read),
        .i_mstatus      (mstatus),
        .i_meie         (meie),
        .i_mtie         (mtie),
        .i_external_int (i_riscv_csr_external_int),
        .i_timer_int    (i_riscv_csr_timer_int),
        .i_mtvec        (o_riscv_csr_trap_address),
        .i_mscratch     (mscratch),
        .i_mepc         (o_riscv_csr_return_address),
        .i_mtval        (mtval),
        .i_mcause_int   (mcause_int),
        .i_mcause_code  (mcause_code),
        .o_rdata        (o_riscv_csr_rdata)
    );

endmodule

// File: logic/csr_read_mux.sv
`timescale 1ns/1ps

module csr_read_mux import riscv_csr_pkg::*; #(
    parameter int MXLEN = 64
) (
    input  logic [11:0]      i_address,
    input  logic             i_read,
    input  mstatus_t         i_mstatus,
    input  logic             i_meie,
    input  logic             i_mtie,
    input  logic             i_external_int,
    input  logic             i_timer_int,
    input  logic [MXLEN-1:0] i_mtvec,
    input  logic [MXLEN-1:0] i_mscratch,
    input  logic [MXLEN-1:0] i_mepc,
    input  logic [MXLEN-1:0] i_mtval,
    input  logic             i_mcause_int,
    input  logic [3:0]       i_mcause_code,
    output logic [MXLEN-1:0] o_rdata
);

    always_comb begin : read_select
        o_rdata = '0;

        // nothing comes out unless a read op is active
        if (i_read) begin
            case (i_address)
                // identity regs are not implemented
                CSR_MVENDORID,
                CSR_MARCHID,
                CSR_MIMPID: o_rdata = '0;
                CSR_MISA:   o_rdata = ISA_CODE;
                CSR_MSTATUS: begin
                    o_rdata[MSTATUS_MIE_BIT]                = i_mstatus.mie;
                    o_rdata[MSTATUS_MPIE_BIT]               = i_mstatus.mpie;
                    o_rdata[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = i_mstatus.mpp;
                end
                CSR_MIE: begin
                    o_rdata[IRQ_M_EXT]   = i_meie;
                    o_rdata[IRQ_M_TIMER] = i_mtie;
                end
                CSR_MIP: begin
                    // pending bits are the raw lines
                    o_rdata[IRQ_M_EXT]   = i_external_int;
                    o_rdata[IRQ_M_TIMER] = i_timer_int;
                end
                CSR_MTVEC:    o_rdata = i_mtvec;
                CSR_MSCRATCH: o_rdata = i_mscratch;
                CSR_MEPC:     o_rdata = i_mepc;
                CSR_MCAUSE: begin
                    o_rdata[MXLEN-1] = i_mcause_int;
                    o_rdata[3:0]     = i_mcause_code;
                end
                CSR_MTVAL: o_rdata = i_mtval;
                default:   o_rdata = '0;
            endcase
        end
    end

endmodule

// File: logic/csr_regs.sv
`timescale 1ns/1ps

module csr_regs import riscv_csr_pkg::*; #(
    parameter int MXLEN = 64
) (
    input  logic             i_riscv_csr_clk,
    input  logic             i_riscv_csr_rst,
    input  logic [11:0]      i_address,
    input  logic             i_we,
    input  logic [MXLEN-1:0] i_wdata,
    input  logic             i_goto_trap,
    input  logic             i_return_from_trap,
    input  trap_info_t       i_trap,
    input  logic [MXLEN-1:0] i_pc,
    output mstatus_t         o_mstatus,
    output logic             o_meie,
    output logic             o_mtie,
    output logic [MXLEN-1:0] o_mtvec,
    output logic [MXLEN-1:0] o_mscratch,
    output logic [MXLEN-1:0] o_mepc,
    output logic [MXLEN-1:0] o_mtval,
    output logic             o_mcause_int,
    output logic [3:0]       o_mcause_code,
    output logic             o_flush
);

    // direct mode only so the two low bits are never stored
    logic [MXLEN-3:0] mtvec_base;
    // bit 0 of mepc is always zero
    logic [MXLEN-2:0] mepc_hi;

    assign o_mtvec = {mtvec_base, 2'b00};
    assign o_mepc  = {mepc_hi, 1'b0};

    // mstatus write changes interrupt state so the pipeline refetches
    assign o_flush = i_we && (i_address == CSR_MSTATUS) && !i_goto_trap;

    always_ff @(posedge i_riscv_csr_clk) begin
        if (!i_riscv_csr_rst) begin
            o_mstatus     <= '0;
            o_meie        <= 1'b0;
            o_mtie        <= 1'b0;
            mtvec_base    <= '0;
            o_mscratch    <= '0;
            mepc_hi       <= '0;
            o_mtval       <= '0;
            o_mcause_int  <= 1'b0;
            o_mcause_code <= 4'd0;
        end else if (i_goto_trap) begin
            // trap entry beats any csr write this cycle
            mepc_hi        <= i_pc[MXLEN-1:1];
            o_mcause_int   <= i_trap.is_interrupt;
            o_mcause_code  <= i_trap.code;
            o_mtval        <= i_trap.tval;
            o_mstatus.mpie <= o_mstatus.mie;
            o_mstatus.mie  <= 1'b0;
            o_mstatus.mpp  <= PRIV_LVL_M;
        end else if (i_return_from_trap) begin
            // mret restores the saved enable
            o_mstatus.mie  <= o_mstatus.mpie;
            o_mstatus.mpie <= 1'b1;
            o_mstatus.mpp  <= PRIV_LVL_M;
        end else if (i_we) begin
            case (i_address)
                CSR_MSTATUS: begin
                    o_mstatus.mie  <= i_wdata[MSTATUS_MIE_BIT];
                    o_mstatus.mpie <= i_wdata[MSTATUS_MPIE_BIT];
                    o_mstatus.mpp  <= i_wdata[MSTATUS_MPP_HI:MSTATUS_MPP_LO];
                end
                CSR_MIE: begin
                    o_meie <= i_wdata[IRQ_M_EXT];
                    o_mtie <= i_wdata[IRQ_M_TIMER];
                end
                CSR_MTVEC:    mtvec_base <= i_wdata[MXLEN-1:2];
                CSR_MSCRATCH: o_mscratch <= i_wdata;
                CSR_MEPC:     mepc_hi    <= i_wdata[MXLEN-1:1];
                CSR_MCAUSE: begin
                    // interrupt flag sits in the top bit
                    o_mcause_int  <= i_wdata[MXLEN-1];
                    o_mcause_code <= i_wdata[3:0];
                end
                CSR_MTVAL: o_mtval <= i_wdata;
                // mip follows the lines and identity regs are read only
                default: ;
            endcase
        end
    end

endmodule

// File: logic/csr_trap_ctrl.sv
`timescale 1ns/1ps

module csr_trap_ctrl import riscv_csr_pkg::*; #(
    parameter int MXLEN = 64
) (
    input  trap_events_t     i_events,
    input  logic             i_external_int,
    input  logic             i_timer_int,
    input  logic             i_mie_global,
    input  logic             i_meie,
    input  logic             i_mtie,
    input  logic             i_mret,
    input  logic [MXLEN-1:0] i_addr_alu,
    output logic             o_goto_trap,
    output logic             o_return_from_trap,
    output trap_info_t       o_trap
);

    logic ext_pending;
    logic timer_pending;
    logic is_exception;
    logic is_interrupt;

    // pending needs global enable and own enable and the live line
    assign ext_pending   = i_mie_global && i_meie && i_external_int;
    assign timer_pending = i_mie_global && i_mtie && i_timer_int;

    assign is_interrupt = ext_pending || timer_pending;
    assign is_exception = |i_events;

    assign o_goto_trap = is_exception || is_interrupt;

    // a trap in the same cycle cancels the return
    assign o_return_from_trap = i_mret && !o_goto_trap;

    always_comb begin : cause_select
        o_trap = '0;

        // exceptions first in fixed order
        if (i_events.inst_misaligned) begin
            o_trap.code = EXC_INST_MISALIGNED;
            o_trap.tval = i_addr_alu;
        end else if (i_events.illegal) begin
            o_trap.code = EXC_ILLEGAL;
        end else if (i_events.ecall_u) begin
            o_trap.code = EXC_ECALL_U;
        end else if (i_events.ecall_s) begin
            o_trap.code = EXC_ECALL_S;
        end else if (i_events.ecall_m) begin
            o_trap.code = EXC_ECALL_M;
        end else if (i_events.load_misaligned) begin
            o_trap.code = EXC_LOAD_MISALIGNED;
            o_trap.tval = i_addr_alu;
        end else if (i_events.store_misaligned) begin
            o_trap.code = EXC_STORE_MISALIGNED;
            o_trap.tval = i_addr_alu;
        end else if (ext_pending) begin
            // external beats timer
            o_trap.is_interrupt = 1'b1;
            o_trap.code         = 4'(IRQ_M_EXT);
        end else if (timer_pending) begin
            o_trap.is_interrupt = 1'b1;
            o_trap.code         = 4'(IRQ_M_TIMER);
        end
    end

endmodule

// File: logic/csr_op_decode.sv
`timescale 1ns/1ps

module csr_op_decode import riscv_csr_pkg::*; #(
    parameter int MXLEN = 64
) (
    input  csr_req_t         i_req,
    input  logic [MXLEN-1:0] i_rdata,
    output logic             o_we,
    output logic             o_read,
    output logic             o_mret,
    output logic [MXLEN-1:0] o_wdata
);

    always_comb begin : op_select
        // defaults pass wdata through untouched
        o_wdata = i_req.wdata;
        o_we    = 1'b0;
        o_read  = 1'b0;
        o_mret  = 1'b0;

        case (i_req.op)
            CSR_WRITE: begin
                o_we   = 1'b1;
                o_read = 1'b1;
            end
            CSR_SET: begin
                // read-modify-write against the current value
                o_we    = 1'b1;
                o_read  = 1'b1;
                o_wdata = i_rdata | i_req.wdata;
            end
            CSR_CLEAR: begin
                o_we    = 1'b1;
                o_read  = 1'b1;
                o_wdata = i_rdata & ~i_req.wdata;
            end
            CSR_READ: o_read = 1'b1;
            // return has no read or write side effect
            MRET: o_mret = 1'b1;
            // idle and old sret code do nothing
            default: ;
        endcase
    end

endmodule

// File: logic/riscv_csr_pkg.sv
package riscv_csr_pkg;

    // machine information registers
    localparam logic [11:0] CSR_MVENDORID = 12'hF11;
    localparam logic [11:0] CSR_MARCHID   = 12'hF12;
    localparam logic [11:0] CSR_MIMPID    = 12'hF13;

    // machine trap setup
    localparam logic [11:0] CSR_MSTATUS   = 12'h300;
    localparam logic [11:0] CSR_MISA      = 12'h301;
    localparam logic [11:0] CSR_MIE       = 12'h304;
    localparam logic [11:0] CSR_MTVEC     = 12'h305;

    // machine trap handling
    localparam logic [11:0] CSR_MSCRATCH  = 12'h340;
    localparam logic [11:0] CSR_MEPC      = 12'h341;
    localparam logic [11:0] CSR_MCAUSE    = 12'h342;
    localparam logic [11:0] CSR_MTVAL     = 12'h343;
    localparam logic [11:0] CSR_MIP       = 12'h344;

    // op codes from the decode stage
    // 3'b110 was sret and now falls into idle
    typedef enum logic [2:0] {
        CSR_IDLE  = 3'b000,
        CSR_WRITE = 3'b001,
        CSR_SET   = 3'b010,
        CSR_CLEAR = 3'b011,
        CSR_READ  = 3'b101,
        MRET      = 3'b111
    } csr_op_e;

    // mstatus field positions
    localparam int unsigned MSTATUS_MIE_BIT  = 3;
    localparam int unsigned MSTATUS_MPIE_BIT = 7;
    localparam int unsigned MSTATUS_MPP_LO   = 11;
    localparam int unsigned MSTATUS_MPP_HI   = 12;

    // mie/mip bit and interrupt cause code
    localparam int unsigned IRQ_M_TIMER = 7;
    localparam int unsigned IRQ_M_EXT   = 11;

    // exception cause codes
    localparam logic [3:0] EXC_INST_MISALIGNED  = 4'd0;
    localparam logic [3:0] EXC_ILLEGAL          = 4'd2;
    localparam logic [3:0] EXC_LOAD_MISALIGNED  = 4'd4;
    localparam logic [3:0] EXC_STORE_MISALIGNED = 4'd6;
    localparam logic [3:0] EXC_ECALL_U          = 4'd8;
    localparam logic [3:0] EXC_ECALL_S          = 4'd9;
    localparam logic [3:0] EXC_ECALL_M          = 4'd11;

    localparam logic [1:0] PRIV_LVL_M = 2'b11;

    // A C I M S U with MXL = 2 for rv64
    localparam logic [63:0] ISA_CODE = (64'd1 << 0)
                                     | (64'd1 << 2)
                                     | (64'd1 << 8)
                                     | (64'd1 << 12)
                                     | (64'd1 << 18)
                                     | (64'd1 << 20)
                                     | (64'd2 << 62);

    // one access from the pipeline
    typedef struct packed {
        csr_op_e     op;
        logic [11:0] address;
        logic [63:0] wdata;
    } csr_req_t;

    // synchronous exception flags
    typedef struct packed {
        logic inst_misaligned;
        logic illegal;
        logic ecall_u;
        logic ecall_s;
        logic ecall_m;
        logic load_misaligned;
        logic store_misaligned;
    } trap_events_t;

    // only the machine fields of mstatus are kept
    typedef struct packed {
        logic       mie;
        logic       mpie;
        logic [1:0] mpp;
    } mstatus_t;

    // what gets latched into mcause and mtval
    typedef struct packed {
        logic        is_interrupt;
        logic [3:0]  code;
        logic [63:0] tval;
    } trap_info_t;

endpackage
